// ==== list.f ====
+incdir+src
src/mem_map_pkg.sv
src/bus_pkg.sv
src/tcm_dp.sv
src/mem_router.sv
src/l1_req_arbiter.sv
src/aquila_fabric_top.sv
test/tb_aquila_fabric.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tb_aquila_fabric -Mdir obj_dir

./obj_dir/Vtb_aquila_fabric > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log

// ==== test/tb_aquila_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

// Behavioral target, ready two cycles after the strobe
module resp_model #(
    parameter bus_pkg::word_t KEY = '0
) (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 strobe_i,
    input  wire bus_pkg::word_t addr_i,
    output bus_pkg::mem_rsp_t   rsp_o
);
    import bus_pkg::*;

    logic     pend_q;
    word_t    addr_q;
    mem_rsp_t rsp_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= 1'b0;
            addr_q <= '0;
            rsp_q  <= '0;
        end else begin
            pend_q <= strobe_i;
            if (strobe_i) begin
                addr_q <= addr_i;
            end
            rsp_q.ready <= pend_q;
            rsp_q.rdata <= addr_q ^ KEY;
        end
    end

    // Quiet bus while in reset
    assign rsp_o = rst_i ? '0 : rsp_q;

endmodule

module tb_aquila_fabric;
    import bus_pkg::*;

    typedef enum logic {PORT_CODE, PORT_DATA} port_e;
    typedef enum logic [2:0] {
        TGT_TCM, TGT_ICACHE, TGT_DCACHE, TGT_DEVICE, TGT_CLINT, TGT_FAKE
    } target_e;

    // One stimulus row with its expected routing and data
    typedef struct packed {
        port_e    port;
        logic     rw;
        word_t    addr;
        byte_en_t byte_en;
        word_t    wdata;
        target_e  target;
        logic     chk;
        word_t    exp;
    } step_t;

    localparam int    NUM_ROWS  = 18;
    localparam int    RSP_BOUND = 8;
    localparam word_t DEV_KEY   = 32'h5a5a_0001;
    localparam word_t CLINT_KEY = 32'h3c3c_0002;
    localparam word_t IC_KEY    = 32'h0f0f_0003;
    localparam word_t DC_KEY    = 32'hf0f0_0004;

    logic       clk;
    logic       rst;
    code_req_t  code_req;
    mem_rsp_t   code_rsp;
    data_req_t  data_req;
    mem_rsp_t   data_rsp;
    code_req_t  icache_req;
    mem_rsp_t   icache_rsp;
    data_req_t  dcache_req;
    mem_rsp_t   dcache_rsp;
    data_req_t  device_req;
    mem_rsp_t   device_rsp;
    data_req_t  clint_req;
    mem_rsp_t   clint_rsp;
    imiss_req_t imiss;
    dmiss_req_t dmiss;
    logic       imiss_ready;
    logic       dmiss_ready;
    cu_req_t    cu_req;
    logic       cu_ready;
    step_t      steps [NUM_ROWS];
    integer     seed;

    aquila_fabric_top DUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .code_req_i    (code_req),
        .code_rsp_o    (code_rsp),
        .data_req_i    (data_req),
        .data_rsp_o    (data_rsp),
        .icache_req_o  (icache_req),
        .icache_rsp_i  (icache_rsp),
        .dcache_req_o  (dcache_req),
        .dcache_rsp_i  (dcache_rsp),
        .device_req_o  (device_req),
        .device_rsp_i  (device_rsp),
        .clint_req_o   (clint_req),
        .clint_rsp_i   (clint_rsp),
        .imiss_i       (imiss),
        .dmiss_i       (dmiss),
        .imiss_ready_o (imiss_ready),
        .dmiss_ready_o (dmiss_ready),
        .cu_req_o      (cu_req),
        .cu_ready_i    (cu_ready)
    );

    // Target models, each with its own rdata key
    resp_model #(.KEY(DEV_KEY)) u_device (
        .clk_i(clk), .rst_i(rst), .strobe_i(device_req.strobe),
        .addr_i(device_req.addr), .rsp_o(device_rsp)
    );
    resp_model #(.KEY(CLINT_KEY)) u_clint (
        .clk_i(clk), .rst_i(rst), .strobe_i(clint_req.strobe),
        .addr_i(clint_req.addr), .rsp_o(clint_rsp)
    );
    resp_model #(.KEY(IC_KEY)) u_icache (
        .clk_i(clk), .rst_i(rst), .strobe_i(icache_req.strobe),
        .addr_i(icache_req.addr), .rsp_o(icache_rsp)
    );
    resp_model #(.KEY(DC_KEY)) u_dcache (
        .clk_i(clk), .rst_i(rst), .strobe_i(dcache_req.strobe),
        .addr_i(dcache_req.addr), .rsp_o(dcache_rsp)
    );

    // ----------------------------------------
    // Clock, watchdog and error exit
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Table rows plus the two miss sequences, 40 cycles each
    initial begin
        repeat ((NUM_ROWS + 2) * 40) @(posedge clk);
        stop_run("Watchdog timeout, the tests did not finish in time");
    end

    // ----------------------------------------
    // Expected values from the address map
    // ----------------------------------------
    function automatic step_t make_step(port_e p, logic rw, word_t addr, byte_en_t be,
                                        word_t wdata, target_e t, logic chk, word_t exp);
        step_t s;
        s = '{port: p, rw: rw, addr: addr, byte_en: be, wdata: wdata,
              target: t, chk: chk, exp: exp};
        return s;
    endfunction

    // Enabled bytes come from the new word
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    // Order is icache, dcache, device, CLINT
    function automatic logic [3:0] strobe_mask(target_e t);
        case (t)
            TGT_ICACHE: return 4'b1000;
            TGT_DCACHE: return 4'b0100;
            TGT_DEVICE: return 4'b0010;
            TGT_CLINT:  return 4'b0001;
            default:    return 4'b0000;
        endcase
    endfunction

    function automatic int latency_of(target_e t);
        return (t == TGT_TCM || t == TGT_FAKE) ? 1 : 2;
    endfunction

    // Address seen on the target's own port
    function automatic word_t forwarded_addr(target_e t);
        case (t)
            TGT_ICACHE: return icache_req.addr;
            TGT_DCACHE: return dcache_req.addr;
            TGT_DEVICE: return device_req.addr;
            TGT_CLINT:  return clint_req.addr;
            default:    return '0;
        endcase
    endfunction

    function automatic string req_port_name(target_e t);
        case (t)
            TGT_ICACHE: return "icache_req_o";
            TGT_DCACHE: return "dcache_req_o";
            TGT_DEVICE: return "device_req_o";
            default:    return "clint_req_o";
        endcase
    endfunction

    task automatic fill_table;
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        // TCM partial writes, then reads on both ports
        steps[0]  = make_step(PORT_DATA, 1, 32'h0000_0040, 4'hf, w0, TGT_TCM, 0, '0);
        steps[1]  = make_step(PORT_DATA, 1, 32'h0000_0040, 4'h5, w1, TGT_TCM, 0, '0);
        steps[2]  = make_step(PORT_DATA, 0, 32'h0000_0040, 4'hf, '0, TGT_TCM, 1,
                              merge_bytes(w0, w1, 4'h5));
        steps[3]  = make_step(PORT_CODE, 0, 32'h0000_0040, 4'h0, '0, TGT_TCM, 1,
                              merge_bytes(w0, w1, 4'h5));
        steps[4]  = make_step(PORT_DATA, 1, 32'h0000_0ffc, 4'hf, w2, TGT_TCM, 0, '0);
        steps[5]  = make_step(PORT_DATA, 1, 32'h0000_0ffc, 4'h8, w3, TGT_TCM, 0, '0);
        steps[6]  = make_step(PORT_DATA, 0, 32'h0000_0ffc, 4'hf, '0, TGT_TCM, 1,
                              merge_bytes(w2, w3, 4'h8));
        // Uncached device
        steps[7]  = make_step(PORT_DATA, 0, 32'hc000_1234, 4'hf, '0, TGT_DEVICE, 1,
                              32'hc000_1234 ^ DEV_KEY);
        steps[8]  = make_step(PORT_DATA, 1, 32'hc000_0010, 4'h3, 32'h1234_abcd,
                              TGT_DEVICE, 0, '0);
        // CLINT and faked system devices
        steps[9]  = make_step(PORT_DATA, 0, 32'hf000_bff8, 4'hf, '0, TGT_CLINT, 1,
                              32'hf000_bff8 ^ CLINT_KEY);
        steps[10] = make_step(PORT_DATA, 1, 32'hf000_4000, 4'hf, 32'h0000_0001,
                              TGT_CLINT, 0, '0);
        steps[11] = make_step(PORT_DATA, 0, 32'hf00f_fff0, 4'hf, '0, TGT_FAKE, 1, '0);
        steps[12] = make_step(PORT_DATA, 1, 32'hf001_0000, 4'hf, 32'hdead_beef,
                              TGT_FAKE, 1, '0);
        // Cached, unclaimed segments included
        steps[13] = make_step(PORT_CODE, 0, 32'h8000_0100, 4'h0, '0, TGT_ICACHE, 1,
                              32'h8000_0100 ^ IC_KEY);
        steps[14] = make_step(PORT_DATA, 0, 32'h8000_0200, 4'hf, '0, TGT_DCACHE, 1,
                              32'h8000_0200 ^ DC_KEY);
        steps[15] = make_step(PORT_DATA, 1, 32'ha000_0004, 4'hf, 32'h5555_aaaa,
                              TGT_DCACHE, 0, '0);
        steps[16] = make_step(PORT_DATA, 0, 32'h4000_0000, 4'hf, '0, TGT_DCACHE, 1,
                              32'h4000_0000 ^ DC_KEY);
        steps[17] = make_step(PORT_CODE, 0, 32'hc000_0000, 4'h0, '0, TGT_ICACHE, 1,
                              32'hc000_0000 ^ IC_KEY);
    endtask

    // ----------------------------------------
    // Core side steps
    // ----------------------------------------
    task automatic apply_step(input step_t s);
        int       k;
        logic     seen;
        logic [3:0] mask;
        mem_rsp_t rsp;
        string    rsp_name;
        rsp_name = (s.port == PORT_CODE) ? "code_rsp_o" : "data_rsp_o";
        @(posedge clk);
        if (s.port == PORT_CODE) begin
            code_req <= '{strobe: 1'b1, addr: s.addr};
        end else begin
            data_req <= '{strobe: 1'b1, rw: s.rw, addr: s.addr,
                          byte_en: s.byte_en, wdata: s.wdata};
        end
        // Strobe cycle, check routing
        @(negedge clk);
        mask = {icache_req.strobe, dcache_req.strobe, device_req.strobe, clint_req.strobe};
        assert (mask == strobe_mask(s.target))
            else stop_run($sformatf(
                "Fail icache/dcache/device/clint_req_o.strobe got %h expected %h for addr %h",
                mask, strobe_mask(s.target), s.addr));
        // TCM and faked devices have no port at the top level
        if (strobe_mask(s.target) != 4'b0000) begin
            assert (forwarded_addr(s.target) == s.addr)
                else stop_run($sformatf("Fail %s.addr got %h expected %h",
                                        req_port_name(s.target),
                                        forwarded_addr(s.target), s.addr));
        end
        if (s.port == PORT_DATA && s.target == TGT_DEVICE) begin
            assert (device_req.wdata == s.wdata && device_req.rw == s.rw)
                else stop_run($sformatf(
                    "Fail device_req_o.wdata/rw got %h/%h expected %h/%h",
                    device_req.wdata, device_req.rw, s.wdata, s.rw));
        end else if (s.port == PORT_DATA) begin
            // Device bus stays blank for other regions
            assert (device_req.addr == '0 && device_req.wdata == '0)
                else stop_run($sformatf("Fail device_req_o addr %h wdata %h expected 0",
                                        device_req.addr, device_req.wdata));
        end
        seen = 1'b0;
        k    = 0;
        while (!seen && k < RSP_BOUND) begin
            @(posedge clk);
            if (k == 0) begin
                code_req.strobe <= 1'b0;
                data_req.strobe <= 1'b0;
            end
            k++;
            @(negedge clk);
            rsp  = (s.port == PORT_CODE) ? code_rsp : data_rsp;
            seen = rsp.ready;
        end
        assert (seen)
            else stop_run($sformatf("No ready for the access to %h within %0d cycles",
                                    s.addr, RSP_BOUND));
        assert (k == latency_of(s.target))
            else stop_run($sformatf("Fail %s.ready latency got %h expected %h",
                                    rsp_name, k, latency_of(s.target)));
        if (s.chk) begin
            assert (rsp.rdata == s.exp)
                else stop_run($sformatf("Fail %s.rdata got %h expected %h at addr %h",
                                        rsp_name, rsp.rdata, s.exp, s.addr));
        end
    endtask

    // ----------------------------------------
    // Miss arbitration
    // ----------------------------------------
    task automatic wait_cu_strobe;
        int n;
        n = 0;
        @(negedge clk);
        while (!cu_req.strobe && n < RSP_BOUND) begin
            @(negedge clk);
            n++;
        end
        assert (cu_req.strobe) else stop_run("No request reached the coherence unit");
    endtask

    task automatic expect_cu(input cu_req_t exp);
        assert (cu_req == exp)
            else stop_run($sformatf("Fail cu_req_o got %h expected %h", cu_req, exp));
    endtask

    task automatic expect_readies(input logic i_rdy, input logic d_rdy);
        assert (imiss_ready == i_rdy && dmiss_ready == d_rdy)
            else stop_run($sformatf("Fail imiss_ready_o/dmiss_ready_o got %h/%h expected %h/%h",
                                    imiss_ready, dmiss_ready, i_rdy, d_rdy));
    endtask

    task automatic check_dual_miss;
        cu_req_t exp_i;
        cu_req_t exp_d;
        exp_i = '{strobe: 1'b1, rw: 1'b0, addr: 32'h8000_1000, share_modify: 1'b0,
                  replacement: 1'b0, is_instr_fetch: 1'b1};
        exp_d = '{strobe: 1'b1, rw: 1'b1, addr: 32'h9000_2040, share_modify: 1'b1,
                  replacement: 1'b0, is_instr_fetch: 1'b0};
        @(posedge clk);
        imiss <= '{strobe: 1'b1, addr: 32'h8000_1000};
        dmiss <= '{strobe: 1'b1, rw: 1'b1, addr: 32'h9000_2040,
                   share_modify: 1'b1, replacement: 1'b0};
        wait_cu_strobe();
        expect_cu(exp_i);
        // Back-pressure, request holds
        repeat (3) begin
            @(negedge clk);
            expect_cu(exp_i);
            expect_readies(1'b0, 1'b0);
        end
        @(posedge clk);
        cu_ready <= 1'b1;
        @(negedge clk);
        expect_readies(1'b1, 1'b0);
        @(posedge clk);
        cu_ready <= 1'b0;
        imiss    <= '0;
        @(negedge clk);
        expect_cu('0);
        // D-cache kept its strobe up
        wait_cu_strobe();
        expect_cu(exp_d);
        @(posedge clk);
        cu_ready <= 1'b1;
        @(negedge clk);
        expect_readies(1'b0, 1'b1);
        @(posedge clk);
        cu_ready <= 1'b0;
        dmiss    <= '0;
        @(negedge clk);
        expect_cu('0);
    endtask

    task automatic check_d_withdraw;
        cu_req_t exp_d;
        exp_d = '{strobe: 1'b1, rw: 1'b0, addr: 32'hb000_0080, share_modify: 1'b0,
                  replacement: 1'b1, is_instr_fetch: 1'b0};
        @(posedge clk);
        dmiss <= '{strobe: 1'b1, rw: 1'b0, addr: 32'hb000_0080,
                   share_modify: 1'b0, replacement: 1'b1};
        wait_cu_strobe();
        expect_cu(exp_d);
        @(posedge clk);
        dmiss <= '0;
        @(negedge clk);
        expect_readies(1'b0, 1'b0);
        @(negedge clk);
        expect_readies(1'b0, 1'b0);
        expect_cu('0);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed     = 32'hf7b5_aa26;
        rst      <= 1'b1;
        code_req <= '0;
        data_req <= '0;
        imiss    <= '0;
        dmiss    <= '0;
        cu_ready <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        fill_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_step(steps[i]);
        end
        check_dual_miss();
        check_d_withdraw();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/aquila_fabric_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aquila_fabric_top (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire bus_pkg::code_req_t  code_req_i,
    output bus_pkg::mem_rsp_t        code_rsp_o,
    input  wire bus_pkg::data_req_t  data_req_i,
    output bus_pkg::mem_rsp_t        data_rsp_o,
    output bus_pkg::code_req_t       icache_req_o,
    input  wire bus_pkg::mem_rsp_t   icache_rsp_i,
    output bus_pkg::data_req_t       dcache_req_o,
    input  wire bus_pkg::mem_rsp_t   dcache_rsp_i,
    output bus_pkg::data_req_t       device_req_o,
    input  wire bus_pkg::mem_rsp_t   device_rsp_i,
    output bus_pkg::data_req_t       clint_req_o,
    input  wire bus_pkg::mem_rsp_t   clint_rsp_i,
    input  wire bus_pkg::imiss_req_t imiss_i,
    input  wire bus_pkg::dmiss_req_t dmiss_i,
    output logic                     imiss_ready_o,
    output logic                     dmiss_ready_o,
    output bus_pkg::cu_req_t         cu_req_o,
    input  wire                      cu_ready_i
);
    import bus_pkg::*;

    // Router to TCM links
    code_req_t tcm_code_req;
    mem_rsp_t  tcm_code_rsp;
    data_req_t tcm_data_req;
    mem_rsp_t  tcm_data_rsp;

    // ----------------------------------------
    // Core side decode and response muxing
    // ----------------------------------------
    mem_router u_router (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .code_req_i     (code_req_i),
        .data_req_i     (data_req_i),
        .code_rsp_o     (code_rsp_o),
        .data_rsp_o     (data_rsp_o),
        .tcm_code_req_o (tcm_code_req),
        .tcm_code_rsp_i (tcm_code_rsp),
        .tcm_data_req_o (tcm_data_req),
        .tcm_data_rsp_i (tcm_data_rsp),
        .icache_req_o   (icache_req_o),
        .icache_rsp_i   (icache_rsp_i),
        .dcache_req_o   (dcache_req_o),
        .dcache_rsp_i   (dcache_rsp_i),
        .device_req_o   (device_req_o),
        .device_rsp_i   (device_rsp_i),
        .clint_req_o    (clint_req_o),
        .clint_rsp_i    (clint_rsp_i)
    );

    // Segment 0 scratchpad
    tcm_dp u_tcm (
        .clk_i      (clk_i),
        .code_req_i (tcm_code_req),
        .code_rsp_o (tcm_code_rsp),
        .data_req_i (tcm_data_req),
        .data_rsp_o (tcm_data_rsp)
    );

    // One miss at a time to the coherence unit
    l1_req_arbiter u_arbiter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .imiss_i       (imiss_i),
        .dmiss_i       (dmiss_i),
        .cu_ready_i    (cu_ready_i),
        .imiss_ready_o (imiss_ready_o),
        .dmiss_ready_o (dmiss_ready_o),
        .cu_req_o      (cu_req_o)
    );

endmodule

`default_nettype wire

// ==== src/l1_req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_req_arbiter (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire bus_pkg::imiss_req_t imiss_i,
    input  wire bus_pkg::dmiss_req_t dmiss_i,
    input  wire                      cu_ready_i,
    output logic                     imiss_ready_o,
    output logic                     dmiss_ready_o,
    output bus_pkg::cu_req_t         cu_req_o
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_I,
        ARB_D
    } arb_state_e;

    arb_state_e state_q;
    arb_state_e state_d;
    cu_req_t    cu_req_d;

    // ----------------------------------------
    // Grant FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                // I miss wins a tie
                if (imiss_i.strobe) begin
                    state_d = ARB_I;
                end else if (dmiss_i.strobe) begin
                    state_d = ARB_D;
                end
            end
            ARB_I: begin
                if (cu_ready_i) begin
                    state_d = ARB_IDLE;
                end
            end
            ARB_D: begin
                // D-cache may withdraw its request
                if (cu_ready_i || !dmiss_i.strobe) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    // Request built from the next state, registered below
    always_comb begin
        cu_req_d = '0;
        case (state_d)
            ARB_I: begin
                cu_req_d.strobe         = 1'b1;
                cu_req_d.addr           = imiss_i.addr;
                cu_req_d.is_instr_fetch = 1'b1;
            end
            ARB_D: begin
                cu_req_d.strobe       = 1'b1;
                cu_req_d.rw           = dmiss_i.rw;
                cu_req_d.addr         = dmiss_i.addr;
                cu_req_d.share_modify = dmiss_i.share_modify;
                cu_req_d.replacement  = dmiss_i.replacement;
            end
            default: cu_req_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= ARB_IDLE;
            cu_req_o <= '0;
        end else begin
            state_q  <= state_d;
            cu_req_o <= cu_req_d;
        end
    end

    // Completion goes only to the granted cache
    assign imiss_ready_o = (state_q == ARB_I) && cu_ready_i;
    assign dmiss_ready_o = (state_q == ARB_D) && cu_ready_i;

    one_miss_ready_a : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({imiss_ready_o, dmiss_ready_o}));

    // Coherence unit sees a gap after each completion
    strobe_drops_a : assert property (@(posedge clk_i) disable iff (rst_i)
        (imiss_ready_o || dmiss_ready_o) |=> !cu_req_o.strobe);

endmodule

`default_nettype wire

// ==== src/mem_router.sv ====
`include "aquila_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mem_router (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire bus_pkg::code_req_t code_req_i,
    input  wire bus_pkg::data_req_t data_req_i,
    output bus_pkg::mem_rsp_t       code_rsp_o,
    output bus_pkg::mem_rsp_t       data_rsp_o,
    output bus_pkg::code_req_t      tcm_code_req_o,
    input  wire bus_pkg::mem_rsp_t  tcm_code_rsp_i,
    output bus_pkg::data_req_t      tcm_data_req_o,
    input  wire bus_pkg::mem_rsp_t  tcm_data_rsp_i,
    output bus_pkg::code_req_t      icache_req_o,
    input  wire bus_pkg::mem_rsp_t  icache_rsp_i,
    output bus_pkg::data_req_t      dcache_req_o,
    input  wire bus_pkg::mem_rsp_t  dcache_rsp_i,
    output bus_pkg::data_req_t      device_req_o,
    input  wire bus_pkg::mem_rsp_t  device_rsp_i,
    output bus_pkg::data_req_t      clint_req_o,
    input  wire bus_pkg::mem_rsp_t  clint_rsp_i
);
    import mem_map_pkg::*;
    import bus_pkg::*;

    seg_t        code_seg;
    seg_t        data_seg;
    sysdev_sel_t sysdev_sel;
    region_e     code_region;
    region_e     data_region;
    logic        clint_hit;
    logic        fake_hit;
    region_e     code_region_r;
    region_e     data_region_r;
    logic        clint_sel_r;
    logic        fake_ready_r;
    mem_rsp_t    sysdev_rsp;

    // Strobe and rw pass only to the selected target
    function automatic data_req_t gate_data(data_req_t req, logic hit);
        data_req_t res;
        res        = req;
        res.strobe = req.strobe && hit;
        res.rw     = req.rw && hit;
        return res;
    endfunction

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign code_seg   = code_req_i.addr[`AQ_XLEN-1 -: 4];
    assign data_seg   = data_req_i.addr[`AQ_XLEN-1 -: 4];
    assign sysdev_sel = data_req_i.addr[19:16];

    // Code side only knows TCM or cache
    assign code_region = (code_seg == `AQ_SEG_TCM) ? REGION_TCM : REGION_CACHED;

    always_comb begin
        case (data_seg)
            `AQ_SEG_TCM:    data_region = REGION_TCM;
            `AQ_SEG_DEVICE: data_region = REGION_DEVICE;
            `AQ_SEG_SYSDEV: data_region = REGION_SYSDEV;
            default:        data_region = REGION_CACHED;
        endcase
    end

    assign clint_hit = (data_region == REGION_SYSDEV) && (sysdev_sel == `AQ_SYSDEV_CLINT);
    // Other system devices are faked, early stack accesses land here
    assign fake_hit  = (data_region == REGION_SYSDEV) && (sysdev_sel != `AQ_SYSDEV_CLINT);

    // ----------------------------------------
    // Target requests
    // ----------------------------------------
    always_comb begin
        tcm_code_req_o        = code_req_i;
        tcm_code_req_o.strobe = code_req_i.strobe && (code_region == REGION_TCM);
        icache_req_o          = code_req_i;
        icache_req_o.strobe   = code_req_i.strobe && (code_region == REGION_CACHED);

        tcm_data_req_o = gate_data(data_req_i, data_region == REGION_TCM);
        dcache_req_o   = gate_data(data_req_i, data_region == REGION_CACHED);
        clint_req_o    = gate_data(data_req_i, clint_hit);

        // Device bus sees zero address and data unless addressed
        device_req_o = gate_data(data_req_i, data_region == REGION_DEVICE);
        if (data_region != REGION_DEVICE) begin
            device_req_o.addr  = '0;
            device_req_o.wdata = '0;
        end
    end

    // ----------------------------------------
    // Response select, captured on strobe
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            code_region_r <= REGION_TCM;
            data_region_r <= REGION_TCM;
            clint_sel_r   <= 1'b0;
            fake_ready_r  <= 1'b0;
        end else begin
            if (code_req_i.strobe) begin
                code_region_r <= code_region;
            end
            if (data_req_i.strobe) begin
                data_region_r <= data_region;
                clint_sel_r   <= clint_hit;
            end
            // Fake device answers the cycle after strobe
            fake_ready_r <= data_req_i.strobe && fake_hit;
        end
    end

    assign sysdev_rsp = clint_sel_r ? clint_rsp_i : mem_rsp_t'{ready: fake_ready_r, rdata: '0};

    assign code_rsp_o = (code_region_r == REGION_TCM) ? tcm_code_rsp_i : icache_rsp_i;

    always_comb begin
        case (data_region_r)
            REGION_TCM:    data_rsp_o = tcm_data_rsp_i;
            REGION_CACHED: data_rsp_o = dcache_rsp_i;
            REGION_DEVICE: data_rsp_o = device_rsp_i;
            default:       data_rsp_o = sysdev_rsp;
        endcase
    end

    // A data strobe reaches one target at most, fake device included
    one_data_target_a : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({tcm_data_req_o.strobe, dcache_req_o.strobe, device_req_o.strobe,
                  clint_req_o.strobe, data_req_i.strobe && fake_hit}));

endmodule

`default_nettype wire

// ==== src/tcm_dp.sv ====
`include "aquila_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module tcm_dp (
    input  wire                 clk_i,
    input  wire bus_pkg::code_req_t code_req_i,
    output bus_pkg::mem_rsp_t   code_rsp_o,
    input  wire bus_pkg::data_req_t data_req_i,
    output bus_pkg::mem_rsp_t   data_rsp_o
);
    import bus_pkg::*;

    localparam int TCM_AW = $clog2(`AQ_TCM_WORDS);

    // Word array, no reset on contents
    word_t mem [`AQ_TCM_WORDS];

    // Word index, byte offset dropped
    logic [TCM_AW-1:0] code_idx;
    logic [TCM_AW-1:0] data_idx;

    assign code_idx = code_req_i.addr[TCM_AW+1:2];
    assign data_idx = data_req_i.addr[TCM_AW+1:2];

    // ----------------------------------------
    // Code port, read only
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (code_req_i.strobe) begin
            code_rsp_o.rdata <= mem[code_idx];
        end
        // Ready one cycle after strobe
        code_rsp_o.ready <= code_req_i.strobe;
    end

    // ----------------------------------------
    // Data port, byte-enabled write
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (data_req_i.strobe) begin
            if (data_req_i.rw) begin
                for (int b = 0; b < `AQ_XLEN/8; b++) begin
                    if (data_req_i.byte_en[b]) begin
                        mem[data_idx][8*b +: 8] <= data_req_i.wdata[8*b +: 8];
                    end
                end
            end
            // Old word returned on a write, core ignores it
            data_rsp_o.rdata <= mem[data_idx];
        end
        data_rsp_o.ready <= data_req_i.strobe;
    end

    // Fetch never races a store into the same word
    code_no_write_a : assert property (@(posedge clk_i)
        !(code_req_i.strobe && data_req_i.strobe && data_req_i.rw &&
          (code_idx == data_idx)));

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
`include "aquila_settings.svh"
`default_nettype none

package bus_pkg;

    // ----------------------------------------
    // Basic bus types
    // ----------------------------------------

    typedef logic [`AQ_XLEN-1:0]   word_t;
    typedef logic [`AQ_XLEN/8-1:0] byte_en_t;

    // ----------------------------------------
    // Core side requests and responses
    // ----------------------------------------

    // Instruction fetch, read only
    typedef struct packed {
        logic  strobe;
        word_t addr;
    } code_req_t;

    // Data access with byte enables
    typedef struct packed {
        logic     strobe;
        logic     rw;
        word_t    addr;
        byte_en_t byte_en;
        word_t    wdata;
    } data_req_t;

    // Ready is a one-cycle pulse with valid rdata
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

    // ----------------------------------------
    // Miss requests toward the coherence unit
    // ----------------------------------------

    typedef struct packed {
        logic  strobe;
        word_t addr;
    } imiss_req_t;

    typedef struct packed {
        logic  strobe;
        logic  rw;
        word_t addr;
        logic  share_modify;
        logic  replacement;
    } dmiss_req_t;

    // Merged request, tagged with the requesting cache
    typedef struct packed {
        logic  strobe;
        logic  rw;
        word_t addr;
        logic  share_modify;
        logic  replacement;
        logic  is_instr_fetch;
    } cu_req_t;

endpackage

`default_nettype wire

// ==== src/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    // ----------------------------------------
    // Address map types
    // ----------------------------------------

    // Top nibble of an address
    typedef logic [3:0] seg_t;

    // Address bits 19:16 inside the system segment
    typedef logic [3:0] sysdev_sel_t;

    // Target region of a request
    // Cached covers 8..B and every unclaimed segment
    typedef enum logic [1:0] {
        REGION_TCM    = 2'd0,
        REGION_CACHED = 2'd1,
        REGION_DEVICE = 2'd2,
        REGION_SYSDEV = 2'd3
    } region_e;

endpackage

`default_nettype wire

// ==== src/aquila_settings.svh ====
`ifndef AQUILA_SETTINGS_SVH
`define AQUILA_SETTINGS_SVH

// Data and address width
`define AQ_XLEN 32

// TCM depth in words
`define AQ_TCM_WORDS 1024

// Segment codes, taken from the top address nibble
`define AQ_SEG_TCM    4'h0
`define AQ_SEG_DEVICE 4'hC
`define AQ_SEG_SYSDEV 4'hF

// System-device select from address bits 19:16
`define AQ_SYSDEV_CLINT 4'h0

`endif
